// File: source/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// raster geometry in clocks and lines
`define VID_HPERIOD     448
`define VID_VPERIOD     320

// horizontal sync and blanking, in beam clocks
`define VID_HSYNC_BEG   11
`define VID_HSYNC_END   43
`define VID_HBLNK_END   88

// vertical blanking and sync, in lines
`define VID_VBLNK_END   32
`define VID_VSYNC_BEG   8
`define VID_VSYNC_END   11

// fetch starts this many clocks ahead of the window
`define VID_FETCH_LEAD  8

// words in flight plus words queued, never more than this
`define VID_CREDITS     4

// clocks from beam position to rendered colour
`define VID_PIPE        2

`endif

// File: source/video_pkg.sv
`default_nettype none

package video_pkg;

	typedef logic [8:0]  hcnt_t;
	typedef logic [8:0]  vcnt_t;
	typedef logic [3:0]  pix_idx_t;
	typedef logic [11:0] rgb_t;
	// four pixels, first one on screen in the top nibble
	typedef logic [15:0] vword_t;
	typedef logic [15:0] vaddr_t;

	// beam position and raster strobes, hs/vs active high here
	typedef struct packed {
		hcnt_t h;
		vcnt_t v;
		logic  hpix;
		logic  vpix;
		logic  blank;
		logic  hs;
		logic  vs;
		logic  line_start;
		logic  frame_start;
	} beam_t;

	// visible window, end positions exclusive
	typedef struct packed {
		hcnt_t hbeg;
		hcnt_t hend;
		vcnt_t vbeg;
		vcnt_t vend;
	} win_t;

	typedef struct packed {
		logic   valid;
		vaddr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic   valid;
		vword_t data;
	} mem_rsp_t;

	// video output, syncs active low
	typedef struct packed {
		rgb_t  rgb;
		logic  hs;
		logic  vs;
		logic  blank;
		hcnt_t h;
		vcnt_t v;
	} pix_t;

	// colour source chosen per pixel by the renderer
	typedef enum logic [1:0] {
		SRC_BLACK,
		SRC_BORDER,
		SRC_PAL
	} px_src_t;

	// beam state while in reset, blanked and no syncs
	localparam beam_t BEAM_IDLE = '{blank: 1'b1, default: '0};

endpackage

`default_nettype wire

// File: source/video_sync.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_sync (
	input  logic             clk,
	input  logic             arst_n,
	input  video_pkg::win_t  win,
	input  video_pkg::hcnt_t int_h,
	input  video_pkg::vcnt_t int_v,
	output video_pkg::beam_t beam,
	output logic             fetch_go,
	output logic             fetch_line_start,
	output logic             int_start,
	output logic             frame,
	output logic             flash
);
	import video_pkg::*;

	localparam hcnt_t H_LAST     = hcnt_t'(`VID_HPERIOD - 1);
	localparam vcnt_t V_LAST     = vcnt_t'(`VID_VPERIOD - 1);
	localparam hcnt_t HSYNC_BEG  = hcnt_t'(`VID_HSYNC_BEG);
	localparam hcnt_t HSYNC_END  = hcnt_t'(`VID_HSYNC_END);
	localparam hcnt_t HBLNK_END  = hcnt_t'(`VID_HBLNK_END);
	localparam vcnt_t VSYNC_BEG  = vcnt_t'(`VID_VSYNC_BEG);
	localparam vcnt_t VSYNC_END  = vcnt_t'(`VID_VSYNC_END);
	localparam vcnt_t VBLNK_END  = vcnt_t'(`VID_VBLNK_END);
	localparam hcnt_t FETCH_LEAD = hcnt_t'(`VID_FETCH_LEAD);

	hcnt_t      hcount;
	vcnt_t      vcount;
	vcnt_t      vnext;
	logic       line_start_c;
	logic       frame_start_c;
	logic       vpix_next;
	logic       vpix_q;
	logic       go_c;
	logic [4:0] flash_ctr;
	beam_t      beam_c;

	assign line_start_c  = hcount == H_LAST;
	assign frame_start_c = line_start_c & (vcount == V_LAST);
	assign vnext         = (vcount == V_LAST) ? '0 : vcount + 1'b1;

	// window check for the line that is about to begin
	assign vpix_next = (vnext >= win.vbeg) & (vnext < win.vend);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hcount <= '0;
			vcount <= '0;
		end
		else
		begin
			hcount <= line_start_c ? '0 : hcount + 1'b1;
			if (line_start_c)
				vcount <= vnext;
		end
	end

	// vertical window flag only changes on a line boundary
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			vpix_q <= 1'b0;
		else if (line_start_c)
			vpix_q <= vpix_next;
	end

	// fetch window opens FETCH_LEAD clocks before hbeg
	assign go_c = vpix_q & (hcount >= win.hbeg - FETCH_LEAD) & (hcount < win.hend);

	always_comb
	begin
		beam_c.h           = hcount;
		beam_c.v           = vcount;
		beam_c.hpix        = (hcount >= win.hbeg) & (hcount < win.hend);
		beam_c.vpix        = vpix_q;
		beam_c.blank       = (hcount < HBLNK_END) | (vcount < VBLNK_END);
		beam_c.hs          = (hcount >= HSYNC_BEG) & (hcount < HSYNC_END);
		beam_c.vs          = (vcount >= VSYNC_BEG) & (vcount < VSYNC_END);
		beam_c.line_start  = line_start_c;
		beam_c.frame_start = frame_start_c;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			beam             <= BEAM_IDLE;
			fetch_go         <= 1'b0;
			fetch_line_start <= 1'b0;
			int_start        <= 1'b0;
		end
		else
		begin
			beam             <= beam_c;
			fetch_go         <= go_c;
			fetch_line_start <= line_start_c & vpix_next;
			int_start        <= (hcount == int_h) & (vcount == int_v);
		end
	end

	// frame counter, bit 4 gives the slow flash rate
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			flash_ctr <= '0;
		else if (frame_start_c)
			flash_ctr <= flash_ctr + 1'b1;
	end

	assign frame = flash_ctr[0];
	assign flash = flash_ctr[4];

	a_hcount_range: assert property (@(posedge clk) disable iff (!arst_n)
		hcount < `VID_HPERIOD);

	// frame start sits on the last line start, both counters wrap right after
	a_frame_wrap: assert property (@(posedge clk) disable iff (!arst_n)
		beam.frame_start |=> (beam.h == '0) && (beam.v == '0));

endmodule

`default_nettype wire

// File: source/video_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_fetch (
	input  logic                clk,
	input  logic                arst_n,
	input  video_pkg::beam_t    beam,
	input  video_pkg::win_t     win,
	input  logic                fetch_go,
	input  logic                fetch_line_start,
	input  logic                pop,
	output video_pkg::mem_req_t req,
	input  video_pkg::mem_rsp_t rsp,
	output video_pkg::vword_t   word,
	output logic                word_ok
);
	import video_pkg::*;

	localparam int PW = $clog2(`VID_CREDITS);
	localparam int CW = $clog2(`VID_CREDITS + 1);

	hcnt_t         span;
	logic [6:0]    words;
	logic [6:0]    k;
	vcnt_t         row;
	vaddr_t        base;
	logic          issue;
	logic [CW-1:0] credits;
	logic [CW-1:0] fill;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	vword_t        fifo_mem [`VID_CREDITS];

	// window width is a multiple of four pixels
	assign span  = win.hend - win.hbeg;
	assign words = span[8:2];
	assign row   = beam.v - win.vbeg;
	assign base  = vaddr_t'(row) * vaddr_t'(words);

	assign issue = fetch_go & (k != words) & (credits != '0);

	assign req.valid = issue;
	assign req.addr  = base + vaddr_t'(k);

	// word index within the line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			k <= '0;
		else if (fetch_line_start)
			k <= '0;
		else if (issue)
			k <= k + 1'b1;
	end

	// one credit per request, back on every pop
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			credits <= CW'(`VID_CREDITS);
		else
			credits <= credits - CW'(issue) + CW'(pop);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else
		begin
			if (rsp.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			fill <= fill + CW'(rsp.valid) - CW'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rsp.valid)
			fifo_mem[wr_ptr] <= rsp.data;
	end

	assign word    = fifo_mem[rd_ptr];
	assign word_ok = fill != '0;

	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= `VID_CREDITS);

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		rsp.valid |-> fill != CW'(`VID_CREDITS));

endmodule

`default_nettype wire

// File: source/video_render.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_render (
	input  logic                clk,
	input  logic                arst_n,
	input  video_pkg::beam_t    beam,
	input  video_pkg::vword_t   word,
	input  logic                word_ok,
	output logic                pop,
	input  logic                pal_wr,
	input  video_pkg::pix_idx_t pal_idx,
	input  video_pkg::rgb_t     pal_rgb,
	input  video_pkg::rgb_t     border,
	output video_pkg::rgb_t     rgb,
	output logic                underrun
);
	import video_pkg::*;

	logic       in_win;
	logic       due;
	logic [1:0] phase;
	logic       starve;
	px_src_t    src1;
	pix_idx_t   idx1;
	logic [11:0] rest;
	rgb_t       pal [16];
	rgb_t       rgb_c;
	rgb_t       rgb_q [`VID_PIPE - 1];

	assign in_win = beam.hpix & beam.vpix;
	// a new word is due on every fourth window pixel
	assign due    = in_win & (phase == 2'd0);
	assign pop    = due & word_ok;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase    <= '0;
			starve   <= 1'b0;
			underrun <= 1'b0;
			src1     <= SRC_BLACK;
		end
		else
		begin
			phase <= in_win ? phase + 1'b1 : 2'd0;
			if (due)
				starve <= !word_ok;
			if (due & !word_ok)
				underrun <= 1'b1;
			if (beam.blank)
				src1 <= SRC_BLACK;
			else if (!in_win)
				src1 <= SRC_BORDER;
			else if (due ? !word_ok : starve)
				src1 <= SRC_BORDER;
			else
				src1 <= SRC_PAL;
		end
	end

	// nibble shifter, top nibble goes out first
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			idx1 <= word[15:12];
			rest <= word[11:0];
		end
		else
		begin
			idx1 <= rest[11:8];
			rest <= {rest[7:0], 4'h0};
		end
	end

	always_ff @(posedge clk)
	begin
		if (pal_wr)
			pal[pal_idx] <= pal_rgb;
	end

	always_comb
	begin
		case (src1)
			SRC_PAL:    rgb_c = pal[idx1];
			SRC_BORDER: rgb_c = border;
			default:    rgb_c = '0;
		endcase
	end

	// remaining latency up to VID_PIPE
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `VID_PIPE - 1; i++)
				rgb_q[i] <= '0;
		end
		else
		begin
			rgb_q[0] <= rgb_c;
			for (int i = 1; i < `VID_PIPE - 1; i++)
				rgb_q[i] <= rgb_q[i - 1];
		end
	end

	assign rgb = rgb_q[`VID_PIPE - 2];

endmodule

`default_nettype wire

// File: source/video_out.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_out (
	input  logic             clk,
	input  logic             arst_n,
	input  video_pkg::beam_t beam,
	input  video_pkg::rgb_t  rgb,
	output video_pkg::pix_t  pix
);
	import video_pkg::*;

	beam_t dly [`VID_PIPE];
	beam_t late;

	// beam delayed to line up with the rendered colour
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `VID_PIPE; i++)
				dly[i] <= BEAM_IDLE;
		end
		else
		begin
			dly[0] <= beam;
			for (int i = 1; i < `VID_PIPE; i++)
				dly[i] <= dly[i - 1];
		end
	end

	assign late = dly[`VID_PIPE - 1];

	// output register, syncs turned active low here
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pix <= '{hs: 1'b1, vs: 1'b1, blank: 1'b1, default: '0};
		else
		begin
			pix.rgb   <= rgb;
			pix.hs    <= ~late.hs;
			pix.vs    <= ~late.vs;
			pix.blank <= late.blank;
			pix.h     <= late.h;
			pix.v     <= late.v;
		end
	end

endmodule

`default_nettype wire

// File: source/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top (
	input  logic                clk,
	input  logic                arst_n,
	input  video_pkg::win_t     win,
	input  video_pkg::hcnt_t    int_h,
	input  video_pkg::vcnt_t    int_v,
	input  logic                pal_wr,
	input  video_pkg::pix_idx_t pal_idx,
	input  video_pkg::rgb_t     pal_rgb,
	input  video_pkg::rgb_t     border,
	output video_pkg::mem_req_t req,
	input  video_pkg::mem_rsp_t rsp,
	output video_pkg::pix_t     pix,
	output logic                int_start,
	output logic                frame,
	output logic                flash,
	output logic                underrun
);
	import video_pkg::*;

	beam_t  beam;
	logic   fetch_go;
	logic   fetch_line_start;
	logic   pop;
	vword_t word;
	logic   word_ok;
	rgb_t   rgb;

	video_sync u_sync (
		.clk              (clk),
		.arst_n           (arst_n),
		.win              (win),
		.int_h            (int_h),
		.int_v            (int_v),
		.beam             (beam),
		.fetch_go         (fetch_go),
		.fetch_line_start (fetch_line_start),
		.int_start        (int_start),
		.frame            (frame),
		.flash            (flash)
	);

	video_fetch u_fetch (
		.clk              (clk),
		.arst_n           (arst_n),
		.beam             (beam),
		.win              (win),
		.fetch_go         (fetch_go),
		.fetch_line_start (fetch_line_start),
		.pop              (pop),
		.req              (req),
		.rsp              (rsp),
		.word             (word),
		.word_ok          (word_ok)
	);

	video_render u_render (
		.clk      (clk),
		.arst_n   (arst_n),
		.beam     (beam),
		.word     (word),
		.word_ok  (word_ok),
		.pop      (pop),
		.pal_wr   (pal_wr),
		.pal_idx  (pal_idx),
		.pal_rgb  (pal_rgb),
		.border   (border),
		.rgb      (rgb),
		.underrun (underrun)
	);

	video_out u_out (
		.clk    (clk),
		.arst_n (arst_n),
		.beam   (beam),
		.rgb    (rgb),
		.pix    (pix)
	);

endmodule

`default_nettype wire

// File: verif/video_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_checker (
	input  logic                  clk,
	input  logic                  arst_n,
	input  video_pkg::win_t       win,
	input  video_pkg::hcnt_t      int_h,
	input  video_pkg::vcnt_t      int_v,
	input  video_pkg::rgb_t       border,
	input  video_pkg::rgb_t [15:0] pal,
	input  video_pkg::mem_req_t   req,
	input  video_pkg::mem_rsp_t   rsp,
	input  video_pkg::pix_t       pix,
	input  logic                  int_start,
	input  logic                  frame,
	input  logic                  flash,
	input  logic                  underrun,
	input  logic                  done,
	output int                    frames_done,
	output int                    errors,
	output logic                  reported
);
	import video_pkg::*;

	localparam int N_TESTS = 5;

	int   checks [N_TESTS];
	int   errs [N_TESTS];
	logic started = 1'b0;
	pix_t prev;
	int   lo_run = 0;
	int   since_fall = 0;
	logic seen_fall = 1'b0;
	int   outstanding = 0;
	int   visible_seen = 0;
	int   int_pulses = 0;
	logic frame_prev = 1'b0;
	int   boundaries = 0;
	int   total_err = 0;
	logic report_ok = 1'b0;
	// int_start arrives VID_PIPE+1 clocks before its pixel
	logic [`VID_PIPE+1:0] int_hist = '0;

	assign frames_done = boundaries;
	assign errors      = total_err;
	assign reported    = report_ok;

	function automatic string test_name(input int t);
		case (t)
			0:       return "syncs";
			1:       return "visible pixels";
			2:       return "border and blank";
			3:       return "credits";
			default: return "frame and interrupt";
		endcase
	endfunction

	function automatic logic inside_window(input int h, input int v);
		return h >= int'(win.hbeg) && h < int'(win.hend) &&
			v >= int'(win.vbeg) && v < int'(win.vend);
	endfunction

	// colour that the raster rules give for one beam position
	function automatic rgb_t expected_rgb(input int h, input int v);
		int     dx;
		int     dy;
		int     words;
		vword_t w;
		if (h < `VID_HBLNK_END || v < `VID_VBLNK_END)
			return '0;
		if (!inside_window(h, v))
			return border;
		dx    = h - int'(win.hbeg);
		dy    = v - int'(win.vbeg);
		words = (int'(win.hend) - int'(win.hbeg)) / 4;
		w     = vword_t'(dy * words + dx / 4) ^ 16'h5a3c;
		// leftmost pixel sits in the top nibble
		return pal[pix_idx_t'(w >> (12 - 4 * (dx % 4)))];
	endfunction

	task automatic note_error(input int t, input string msg);
		errs[t]++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	always @(negedge clk)
	begin
		int   h;
		int   v;
		int   exp_h;
		int   exp_v;
		rgb_t exp_rgb;
		logic exp_blank;
		logic exp_flash;
		if (arst_n)
		begin
			int_hist = {int_hist[`VID_PIPE:0], int_start};
			if (req.valid)
				outstanding++;
			if (rsp.valid)
				outstanding--;
			checks[3]++;
			if (outstanding > `VID_CREDITS || outstanding < 0)
				note_error(3, $sformatf("%0d requests outstanding", outstanding));
			if (underrun)
				note_error(3, "underrun flag is set");
			h = int'(pix.h);
			v = int'(pix.v);
			if (started)
			begin
				exp_h = (int'(prev.h) == `VID_HPERIOD - 1) ? 0 : int'(prev.h) + 1;
				exp_v = int'(prev.v);
				if (exp_h == 0)
					exp_v = (exp_v == `VID_VPERIOD - 1) ? 0 : exp_v + 1;
				checks[0] += 2;
				if (h != exp_h || v != exp_v)
					note_error(0, $sformatf("position h=%0d v=%0d, expected h=%0d v=%0d",
						h, v, exp_h, exp_v));
				if (pix.vs != !(v >= `VID_VSYNC_BEG && v < `VID_VSYNC_END))
					note_error(0, $sformatf("vs=%b on line %0d", pix.vs, v));
				// hsync width and falling edge spacing
				since_fall++;
				if (!pix.hs)
					lo_run++;
				if (!prev.hs && pix.hs)
				begin
					checks[0]++;
					if (lo_run != `VID_HSYNC_END - `VID_HSYNC_BEG)
						note_error(0, $sformatf("hs low for %0d clocks", lo_run));
					lo_run = 0;
				end
				if (prev.hs && !pix.hs)
				begin
					if (seen_fall)
					begin
						checks[0]++;
						if (since_fall != `VID_HPERIOD)
							note_error(0, $sformatf("line length %0d", since_fall));
					end
					seen_fall  = 1'b1;
					since_fall = 0;
				end
				exp_rgb   = expected_rgb(h, v);
				exp_blank = h < `VID_HBLNK_END || v < `VID_VBLNK_END;
				if (inside_window(h, v))
				begin
					checks[1]++;
					visible_seen++;
					if (pix.rgb != exp_rgb)
						note_error(1, $sformatf("rgb %h at h=%0d v=%0d, expected %h",
							pix.rgb, h, v, exp_rgb));
				end
				else
				begin
					checks[2]++;
					if (pix.rgb != exp_rgb)
						note_error(2, $sformatf("rgb %h at h=%0d v=%0d, expected %h",
							pix.rgb, h, v, exp_rgb));
				end
				checks[2]++;
				if (pix.blank != exp_blank)
					note_error(2, $sformatf("blank=%b at h=%0d v=%0d", pix.blank, h, v));
				checks[4]++;
				if (int_hist[`VID_PIPE+1] != (pix.h == int_h && pix.v == int_v))
					note_error(4, $sformatf("int_start=%b lines up with h=%0d v=%0d",
						int_hist[`VID_PIPE+1], h, v));
				if (int_hist[`VID_PIPE+1])
					int_pulses++;
				if (h == 0 && v == 0)
				begin
					checks[4] += 2;
					if (frame == frame_prev)
						note_error(4, "frame did not toggle at the frame boundary");
					// flash is bit 4 of the number of finished frames
					exp_flash = ((boundaries + 1) / 16) % 2 == 1;
					if (flash != exp_flash)
						note_error(4, $sformatf("flash=%b after %0d frames", flash,
							boundaries + 1));
					frame_prev = frame;
					boundaries++;
				end
			end
			else if (h == 1)
				started = 1'b1;
			prev = pix;
		end
	end

	always @(posedge done)
	begin
		int sum_checks;
		int sum_errs;
		sum_checks = 0;
		sum_errs   = 0;
		if (visible_seen == 0)
		begin
			errs[1]++;
			$display("no pixel inside the window was ever checked");
		end
		if (int_pulses != boundaries)
		begin
			errs[4]++;
			$display("saw %0d interrupts over %0d frames", int_pulses, boundaries);
		end
		for (int t = 0; t < N_TESTS; t++)
		begin
			$display("test %0d %s: %0d checks, %0d errors", t + 1, test_name(t),
				checks[t], errs[t]);
			sum_checks += checks[t];
			sum_errs   += errs[t];
		end
		$display("total: %0d checks, %0d errors", sum_checks, sum_errs);
		total_err = sum_errs;
		// raised after the error count has settled on the port
		report_ok <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/tb_video_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module tb_video_top;
	import video_pkg::*;

	localparam int CLK_NS = 10;
	// three frames of run time plus room for reset and palette loading
	localparam int WATCHDOG_NS = 3 * `VID_HPERIOD * `VID_VPERIOD * CLK_NS + 50000;

	logic        clk;
	logic        arst_n;
	win_t        win;
	hcnt_t       int_h;
	vcnt_t       int_v;
	logic        pal_wr;
	pix_idx_t    pal_idx;
	rgb_t        pal_rgb;
	rgb_t        border;
	mem_req_t    req;
	mem_rsp_t    rsp;
	pix_t        pix;
	logic        int_start;
	logic        frame;
	logic        flash;
	logic        underrun;
	rgb_t [15:0] pal_ref;
	logic        done;
	int          frames_done;
	int          errors;
	logic        reported;

	// memory model state, one entry per request in flight
	int          cycle_no = 0;
	int          last_due = 0;
	int          due_q [$];
	vword_t      data_q [$];

	initial clk = 1'b0;
	always #(CLK_NS / 2) clk = ~clk;

	video_top uut (
		.clk       (clk),
		.arst_n    (arst_n),
		.win       (win),
		.int_h     (int_h),
		.int_v     (int_v),
		.pal_wr    (pal_wr),
		.pal_idx   (pal_idx),
		.pal_rgb   (pal_rgb),
		.border    (border),
		.req       (req),
		.rsp       (rsp),
		.pix       (pix),
		.int_start (int_start),
		.frame     (frame),
		.flash     (flash),
		.underrun  (underrun)
	);

	video_checker chk (
		.clk         (clk),
		.arst_n      (arst_n),
		.win         (win),
		.int_h       (int_h),
		.int_v       (int_v),
		.border      (border),
		.pal         (pal_ref),
		.req         (req),
		.rsp         (rsp),
		.pix         (pix),
		.int_start   (int_start),
		.frame       (frame),
		.flash       (flash),
		.underrun    (underrun),
		.done        (done),
		.frames_done (frames_done),
		.errors      (errors),
		.reported    (reported)
	);

	// requests are taken mid-cycle, answered in order one to six clocks later
	always @(negedge clk)
	begin
		int due;
		if (arst_n && req.valid)
		begin
			due = cycle_no + int'($urandom_range(6, 1));
			if (due <= last_due)
				due = last_due + 1;
			last_due = due;
			due_q.push_back(due);
			data_q.push_back(req.addr ^ 16'h5a3c);
		end
	end

	always @(posedge clk)
	begin
		#1;
		cycle_no++;
		if (due_q.size() != 0 && due_q[0] == cycle_no)
		begin
			rsp.valid = 1'b1;
			rsp.data  = data_q.pop_front();
			void'(due_q.pop_front());
		end
		else
			rsp = '0;
	end

	initial
	begin
		void'($urandom(32'h205e));
		arst_n  = 1'b0;
		win     = '{hbeg: 9'd120, hend: 9'd376, vbeg: 9'd64, vend: 9'd256};
		int_h   = 9'd200;
		int_v   = 9'd100;
		pal_wr  = 1'b0;
		pal_idx = '0;
		pal_rgb = '0;
		rsp     = '0;
		done    = 1'b0;
		border  = rgb_t'($urandom);
		for (int i = 0; i < 16; i++)
			pal_ref[i] = rgb_t'($urandom);
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// palette goes in one entry per clock, long before the first window line
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			#1;
			pal_wr  = 1'b1;
			pal_idx = pix_idx_t'(i);
			pal_rgb = pal_ref[i];
		end
		@(posedge clk);
		#1;
		pal_wr = 1'b0;
		wait (frames_done >= 2);
		@(posedge clk);
		#1;
		done = 1'b1;
		wait (reported);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: the DUT did not complete two frames within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/video_pkg.sv
source/video_sync.sv
source/video_fetch.sv
source/video_render.sv
source/video_out.sv
source/video_top.sv
verif/video_checker.sv
verif/tb_video_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_video_top -f project.f -o sim_video || exit 1
out=$(./obj_dir/sim_video)
echo "$out"
echo "$out" | grep -qx "Verification passed" && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
